// ==== include/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath and address width
`define XLEN 32

// Reorder buffer tag width
`define ROB_TAG_BITS 5

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

// Cycles counted after the memory acknowledge, zero allowed
`define MEM_LATENCY_IN_CYCLES 2

`endif

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [3:0] lat_count_t;

    // Encoded as funct3[1:0]
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } fu_state_t;

    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

endpackage

`default_nettype wire

// ==== verilog/agu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module agu import lsu_pkg::*; (
    input  inst_t      op_inst,
    input  xlen_t      op_rs1,
    input  xlen_t      op_rs2,
    output logic       is_store,
    output xlen_t      addr,
    output mem_size_t  size,
    output byte_en_t   byte_en,
    output xlen_t      wdata,
    output xlen_t      store_value,
    output logic [2:0] funct3
);

    xlen_t imm_s;
    xlen_t imm_i;
    logic [1:0] offset;

    assign is_store = (op_inst[6:0] == OPCODE_STORE);
    assign funct3   = op_inst[14:12];

    // S-type splits the immediate around rd
    assign imm_s = {{(`XLEN-12){op_inst[31]}}, op_inst[31:25], op_inst[11:7]};
    assign imm_i = {{(`XLEN-12){op_inst[31]}}, op_inst[31:20]};

    assign addr   = op_rs1 + (is_store ? imm_s : imm_i);
    assign offset = addr[1:0];
    assign size   = mem_size_t'(funct3[1:0]);

    always_comb begin
        case (size)
            MEM_BYTE: byte_en = byte_en_t'(4'b0001 << offset);
            MEM_HALF: byte_en = byte_en_t'(4'b0011 << offset);  // Upper lane drops at offset 3
            default:  byte_en = 4'b1111;
        endcase
    end

    // Move store bytes into their lanes
    assign wdata = op_rs2 << {offset, 3'b000};

    assign store_value = op_rs2;  // Unshifted store result

endmodule

`default_nettype wire

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module load_align import lsu_pkg::*; (
    input  xlen_t      rdata,
    input  logic [1:0] addr_low,
    input  logic [2:0] funct3,
    output xlen_t      load_value
);

    xlen_t shifted;

    // Addressed byte or half lands in the low bits
    assign shifted = rdata >> {addr_low, 3'b000};

    always_comb begin
        case (funct3)
            3'b000: begin  // LB
                load_value = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            3'b001: begin  // LH
                load_value = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            3'b100: begin  // LBU
                load_value = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            end
            3'b101: begin  // LHU
                load_value = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                load_value = rdata;  // LW ignores the offset
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module dmem import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     mem_req,
    input  logic     is_store,
    input  xlen_t    addr,
    input  byte_en_t byte_en,
    input  xlen_t    wdata,
    output logic     mem_ack,
    output xlen_t    rdata
);

    localparam int IDX_BITS = $clog2(`DMEM_WORDS);

    xlen_t mem [`DMEM_WORDS];
    logic [IDX_BITS-1:0] idx;
    logic access;

    assign idx    = addr[IDX_BITS+1:2];  // Wraps modulo depth
    assign access = mem_req && !mem_ack;  // One access per request

    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clock) begin
        if (access && is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_ack <= 1'b0;
            rdata   <= '0;
        end else begin
            mem_ack <= access;
            if (access && !is_store) rdata <= mem[idx];  // Held until next load
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_fu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module mem_fu_ctrl import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     issue_valid,
    input  inst_t    inst,
    input  xlen_t    rs1_value,
    input  xlen_t    rs2_value,
    input  rob_tag_t rob_tag,
    input  logic     is_store,
    input  xlen_t    store_value,
    input  xlen_t    load_value,
    input  logic     mem_ack,
    input  logic     cdb_ack,
    output logic     issue_ready,
    output inst_t    op_inst,
    output xlen_t    op_rs1,
    output xlen_t    op_rs2,
    output logic     mem_req,
    output logic     done,
    output rob_tag_t done_rob_tag,
    output xlen_t    done_value
);

    fu_state_t state;
    lat_count_t lat_cnt;
    logic accept;
    xlen_t result;

    assign issue_ready = (state == IDLE);
    assign mem_req     = (state == REQ);
    assign done        = (state == DONE);
    assign accept      = issue_valid && issue_ready;
    assign result      = is_store ? store_value : load_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) state <= REQ;
                end
                REQ: begin
                    if (mem_ack) begin
                        lat_cnt <= '0;
                        state   <= (`MEM_LATENCY_IN_CYCLES == 0) ? DONE : WAIT;
                    end
                end
                WAIT: begin
                    if (lat_cnt == lat_count_t'(`MEM_LATENCY_IN_CYCLES - 1)) begin
                        state <= DONE;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                DONE: begin
                    if (cdb_ack) state <= IDLE;  // Back-pressure holds here
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operation capture
    always_ff @(posedge clock) begin
        if (accept) begin
            op_inst      <= inst;
            op_rs1       <= rs1_value;
            op_rs2       <= rs2_value;
            done_rob_tag <= rob_tag;
        end
    end

    // Result latched on the way into DONE
    always_ff @(posedge clock) begin
        if ((state == REQ && mem_ack && `MEM_LATENCY_IN_CYCLES == 0) ||
            (state == WAIT && lat_cnt == lat_count_t'(`MEM_LATENCY_IN_CYCLES - 1))) begin
            done_value <= result;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_fu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_fu import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     issue_valid,
    output logic     issue_ready,
    input  inst_t    inst,
    input  xlen_t    rs1_value,
    input  xlen_t    rs2_value,
    input  rob_tag_t rob_tag,
    output logic     done,
    output rob_tag_t done_rob_tag,
    output xlen_t    done_value,
    input  logic     cdb_ack
);

    inst_t      op_inst;
    xlen_t      op_rs1;
    xlen_t      op_rs2;
    logic       is_store;
    xlen_t      addr;
    byte_en_t   byte_en;
    xlen_t      wdata;
    xlen_t      store_value;
    logic [2:0] funct3;
    logic       mem_req;
    logic       mem_ack;
    xlen_t      rdata;
    xlen_t      load_value;

    mem_fu_ctrl i_ctrl (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .inst         (inst),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .rob_tag      (rob_tag),
        .is_store     (is_store),
        .store_value  (store_value),
        .load_value   (load_value),
        .mem_ack      (mem_ack),
        .cdb_ack      (cdb_ack),
        .issue_ready  (issue_ready),
        .op_inst      (op_inst),
        .op_rs1       (op_rs1),
        .op_rs2       (op_rs2),
        .mem_req      (mem_req),
        .done         (done),
        .done_rob_tag (done_rob_tag),
        .done_value   (done_value)
    );

    agu i_agu (
        .op_inst     (op_inst),
        .op_rs1      (op_rs1),
        .op_rs2      (op_rs2),
        .is_store    (is_store),
        .addr        (addr),
        .size        (),  // Folded into byte_en
        .byte_en     (byte_en),
        .wdata       (wdata),
        .store_value (store_value),
        .funct3      (funct3)
    );

    dmem i_dmem (
        .clock    (clock),
        .reset    (reset),
        .mem_req  (mem_req),
        .is_store (is_store),
        .addr     (addr),
        .byte_en  (byte_en),
        .wdata    (wdata),
        .mem_ack  (mem_ack),
        .rdata    (rdata)
    );

    load_align i_load_align (
        .rdata      (rdata),
        .addr_low   (addr[1:0]),
        .funct3     (funct3),
        .load_value (load_value)
    );

endmodule

`default_nettype wire

// ==== dv/mem_fu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module mem_fu_tb import lsu_pkg::*; ();

    localparam int MAX_OPS = 64;
    localparam int VEC_WORDS = 5 * MAX_OPS;  // Five columns per operation

    logic     clock;
    logic     reset;
    logic     issue_valid;
    logic     issue_ready;
    inst_t    inst;
    xlen_t    rs1_value;
    xlen_t    rs2_value;
    rob_tag_t rob_tag;
    logic     done;
    rob_tag_t done_rob_tag;
    xlen_t    done_value;
    logic     cdb_ack;

    int errors;
    int checks;
    int cycle_count;
    int cycle_limit;
    logic [31:0] rng_state;
    logic [31:0] vec_mem [0:VEC_WORDS-1];

    mem_fu i_dut (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .inst         (inst),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .rob_tag      (rob_tag),
        .done         (done),
        .done_rob_tag (done_rob_tag),
        .done_value   (done_value),
        .cdb_ack      (cdb_ack)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0d ns: %s", $time, what);
        end
    endtask

    // Watchdog
    always @(posedge clock) begin
        if (!reset) cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run passed %0d cycles before all operations completed",
                     cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int n_ops;
        int base;
        int edges;
        int delay;
        bit accepted;
        rob_tag_t exp_tag;
        xlen_t exp_value;
        rob_tag_t held_tag;
        xlen_t held_value;
        issue_valid = 1'b0;
        inst        = '0;
        rs1_value   = '0;
        rs2_value   = '0;
        rob_tag     = '0;
        cdb_ack     = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        cycle_limit = 0;
        rng_state   = 32'ha31b;
        for (int i = 0; i < VEC_WORDS; i++) vec_mem[i] = '0;
        $readmemh("dv/mem_fu_vectors.txt", vec_mem);
        n_ops = 0;
        while (n_ops < MAX_OPS && vec_mem[5*n_ops] != '0) n_ops++;  // Zero inst ends list
        if (n_ops == 0) begin
            errors++;
            $display("The vector file held no operations");
        end
        cycle_limit = n_ops * (2 + `MEM_LATENCY_IN_CYCLES + 3 + 4);

        repeat (8) @(posedge clock);
        #2 reset = 1'b0;
        check(issue_ready === 1'b1, "issue_ready low after reset");
        check(done === 1'b0, "done high after reset");

        for (int op = 0; op < n_ops; op++) begin
            base      = 5 * op;
            exp_tag   = rob_tag_t'(vec_mem[base+3]);
            exp_value = vec_mem[base+4];
            issue_valid = 1'b1;
            inst        = vec_mem[base];
            rs1_value   = vec_mem[base+1];
            rs2_value   = vec_mem[base+2];
            rob_tag     = exp_tag;
            accepted = 1'b0;
            while (!accepted) begin
                accepted = issue_ready;  // Stable until the coming edge
                @(posedge clock);
                #2;
            end
            issue_valid = 1'b0;
            // Issue inputs move while the operation is in flight
            inst        = ~inst;
            rs1_value   = ~rs1_value;
            rs2_value   = ~rs2_value;
            rob_tag     = ~exp_tag;

            edges = 0;
            while (!done) begin
                check(issue_ready === 1'b0, $sformatf("op %0d: issue_ready high while busy", op));
                @(posedge clock);
                #2;
                edges++;
            end
            check(edges == 2 + `MEM_LATENCY_IN_CYCLES,
                  $sformatf("op %0d: done after %0d edges, expected %0d",
                            op, edges, 2 + `MEM_LATENCY_IN_CYCLES));
            check(done_rob_tag === exp_tag,
                  $sformatf("op %0d: done_rob_tag %h, expected %h", op, done_rob_tag, exp_tag));
            check(done_value === exp_value,
                  $sformatf("op %0d: done_value %h, expected %h", op, done_value, exp_value));

            // Hold off the completion side
            held_tag   = done_rob_tag;
            held_value = done_value;
            rng_state  = next_random(rng_state);
            delay      = int'(rng_state[1:0]);
            repeat (delay) begin
                @(posedge clock);
                #2;
                check(done === 1'b1 && done_rob_tag === held_tag &&
                      done_value === held_value && issue_ready === 1'b0,
                      $sformatf("op %0d: completion outputs moved under back-pressure", op));
            end
            cdb_ack = 1'b1;
            @(posedge clock);
            #2;
            cdb_ack = 1'b0;
            check(done === 1'b0, $sformatf("op %0d: done still high after cdb_ack", op));
            check(issue_ready === 1'b1,
                  $sformatf("op %0d: issue_ready low after completion", op));
        end

        $display("Operations: %0d, checks: %0d, errors: %0d", n_ops, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_fu.f ====
+incdir+include
verilog/lsu_pkg.sv
verilog/agu.sv
verilog/load_align.sv
verilog/dmem.sv
verilog/mem_fu_ctrl.sv
verilog/mem_fu.sv
dv/mem_fu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mem_fu_tb
FILELIST  = mem_fu.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/mem_fu_vectors.txt ====
// Columns: inst rs1 rs2 rob_tag expected_done_value, all hex
// One operation per line, in issue order, memory starts at zero
0020A823 00000100 DEADBEEF 00000001 DEADBEEF
0040A183 0000010C 00000000 00000002 DEADBEEF
0020A023 00000200 11223344 00000003 11223344
00208023 00000201 AAAAAA55 00000004 AAAAAA55
002081A3 00000200 000000EE 00000005 000000EE
002080A3 000001FF 12345680 00000006 12345680
00208023 00000202 000000C3 00000007 000000C3
0000A183 00000200 00000000 00000008 EEC35580
00209023 00000204 FFFF8001 00000009 FFFF8001
00209023 00000206 0000F00D 0000000A 0000F00D
0000A183 00000204 00000000 0000000B F00D8001
0020A023 00000208 A5A5A5A5 0000000C A5A5A5A5
00209023 00000209 00001234 0000000D 00001234
00209023 0000020B 000077BB 0000000E 000077BB
0000A183 00000208 00000000 0000000F BB1234A5
00008183 00000200 00000000 00000010 FFFFFF80
0000C183 00000200 00000000 00000011 00000080
00008183 00000203 00000000 00000012 FFFFFFEE
0000C183 00000202 00000000 00000013 000000C3
00009183 00000200 00000000 00000014 00005580
00009183 00000202 00000000 00000015 FFFFEEC3
0000D183 00000202 00000000 00000016 0000EEC3
00009183 00000204 00000000 00000017 FFFF8001
0000D183 00000204 00000000 00000018 00008001
FE20AE23 00000304 CAFEF00D 00000019 CAFEF00D
FF00A183 00000310 00000000 0000001A CAFEF00D
0020AA23 FFFFFFF0 5EED1234 0000001B 5EED1234
0040A183 00000400 00000000 0000001C 5EED1234
BFC0A183 00000008 00000000 0000001D 5EED1234
FFC0C183 00000307 00000000 0000001E 000000CA
